//--- Makefile
# Verilator build, run and lint for the farthest-point sampler

VERILATOR  := verilator
VFLAGS     := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
TOP        := fpsTb
FILELIST   := sources.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Run did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/fpsTb.sv
// Testbench for the farthest-point sampler
// Loads point sets from a stimulus table, runs the sampler and checks
// samples and packed index words against table values and a software model

`timescale 1ns/1ns

`include "fps_defines.svh"

module fpsTb;

    localparam int NUM_TESTS = 11;
    localparam int MAX_PTS   = `FPS_MAX_POINTS;
    localparam int PACK      = `FPS_PACK_NUM;

    localparam logic [1:0] PAT_HAND  = 2'd0;
    localparam logic [1:0] PAT_RAND  = 2'd1;
    localparam logic [1:0] PAT_EQUAL = 2'd2;

    typedef struct packed {
        logic [`FPS_CNT_WIDTH-1:0]  numPts;
        logic [`FPS_CNT_WIDTH-1:0]  nop;
        logic [1:0]                 kind;
        logic                       disturb;
    } testEntry_t;

    logic                       clk;
    logic                       rst_n;
    fpsDataPkg::pointWrite_t    pointIn;
    fpsCfgPkg::startCmd_t       start;
    fpsCfgPkg::engineStatus_t   status;
    fpsDataPkg::sample_t        sample;
    fpsDataPkg::packedWord_t    word;

    // Stimulus table, hand-placed values sit on the x=y=z diagonal
    testEntry_t tbl     [NUM_TESTS];
    int         handVal [NUM_TESTS][MAX_PTS];
    int         handSeq [NUM_TESTS][MAX_PTS];

    fpsDataPkg::coord_t pts [MAX_PTS];
    int                 expIdx [MAX_PTS];
    int                 expLen;
    int                 testErrs;
    int                 passCount;
    int                 failCount;
    bit                 tableReady;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    fpsTop i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .pointIn (pointIn),
        .start   (start),
        .status  (status),
        .sample  (sample),
        .word    (word)
    );

    //========================================
    // Error reporting
    //========================================
    task automatic reportMismatch(string sig, int got, int exp);
        $display("FAILED at %0t ns: %s got 0x%0h, expected 0x%0h", $time, sig, got, exp);
        testErrs++;
    endtask

    task automatic reportProblem(string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        testErrs++;
    endtask

    //========================================
    // Reference model
    //========================================
    function automatic int sqDist(int a, int b);
        int s;
        int diff;
        s = 0;
        for (int d = 0; d < `FPS_CRD_DIM; d++) begin
            diff = int'(pts[a][d]) - int'(pts[b][d]);
            s += diff * diff;
        end
        return s;
    endfunction

    // Start at 0, then largest minimum distance, lowest index on a tie
    function automatic void modelFps(int numPts);
        int minD  [MAX_PTS];
        bit taken [MAX_PTS];
        int centre;
        int best;
        int bestD;
        for (int i = 0; i < MAX_PTS; i++) begin
            minD[i]  = 32'h7fff_ffff;
            taken[i] = 1'b0;
        end
        expIdx[0] = 0;
        taken[0]  = 1'b1;
        centre    = 0;
        for (int k = 1; k < expLen; k++) begin
            best  = 0;
            bestD = -1;
            for (int i = 0; i < numPts; i++) begin
                if (sqDist(centre, i) < minD[i]) minD[i] = sqDist(centre, i);
                if (!taken[i] && minD[i] > bestD) begin
                    best  = i;
                    bestD = minD[i];
                end
            end
            expIdx[k]   = best;
            taken[best] = 1'b1;
            centre      = best;
        end
    endfunction

    task automatic preparePoints(int t);
        int n;
        n      = int'(tbl[t].numPts);
        expLen = (tbl[t].nop > tbl[t].numPts) ? n : int'(tbl[t].nop);
        for (int i = 0; i < MAX_PTS; i++) begin
            for (int d = 0; d < `FPS_CRD_DIM; d++) begin
                case (tbl[t].kind)
                    PAT_HAND:  pts[i][d] = `FPS_CRD_WIDTH'(handVal[t][i]);
                    PAT_EQUAL: pts[i][d] = `FPS_CRD_WIDTH'(77);
                    default:   pts[i][d] = `FPS_CRD_WIDTH'($urandom());
                endcase
            end
            expIdx[i] = (tbl[t].kind == PAT_HAND) ? handSeq[t][i] : i;
        end
        if (tbl[t].kind == PAT_RAND && expLen > 0) modelFps(n);
    endtask

    //========================================
    // Output checks
    //========================================
    task automatic checkSample(int n);
        if (n >= expLen) begin
            reportProblem("sample strobe beyond the expected number of samples");
        end else begin
            if (int'(sample.idx) != expIdx[n])
                reportMismatch("sample.idx", int'(sample.idx), expIdx[n]);
            if (sample.coord != pts[expIdx[n]])
                reportMismatch("sample.coord", int'(sample.coord), int'(pts[expIdx[n]]));
            if (sample.last != (n == expLen - 1))
                reportMismatch("sample.last", int'(sample.last), int'(n == expLen - 1));
        end
    endtask

    task automatic checkWord(int w);
        int expValid;
        expValid = expLen - w * PACK;
        if (expValid > PACK) expValid = PACK;
        if (expValid <= 0) begin
            reportProblem("packed word strobe beyond the expected number of words");
        end else begin
            if (int'(word.addr) != w)
                reportMismatch("word.addr", int'(word.addr), w);
            if (int'(word.numValid) != expValid)
                reportMismatch("word.numValid", int'(word.numValid), expValid);
            for (int s = 0; s < expValid; s++) begin
                if (int'(word.idx[s]) != expIdx[w * PACK + s])
                    reportMismatch($sformatf("word.idx[%0d]", s), int'(word.idx[s]),
                                   expIdx[w * PACK + s]);
            end
        end
    endtask

    //========================================
    // One table entry
    //========================================
    task automatic runTest(int t);
        int nSamp;
        int nWords;
        bit gotDone;
        testErrs = 0;
        nSamp    = 0;
        nWords   = 0;
        gotDone  = 1'b0;
        preparePoints(t);
        for (int i = 0; i < int'(tbl[t].numPts); i++) begin
            @(posedge clk);
            pointIn <= '{strobe: 1'b1, coord: pts[i]};
        end
        @(posedge clk);
        pointIn.strobe <= 1'b0;
        start          <= '{strobe: 1'b1, nop: tbl[t].nop};
        @(posedge clk);
        if (tbl[t].disturb) begin
            // Second start and an extra far point while the engine is busy
            start   <= '{strobe: 1'b1, nop: `FPS_CNT_WIDTH'(MAX_PTS)};
            pointIn <= '{strobe: 1'b1, coord: '1};
        end else begin
            start.strobe <= 1'b0;
        end
        while (!gotDone) begin
            @(negedge clk);
            if (sample.strobe) begin
                checkSample(nSamp);
                nSamp++;
            end
            if (word.strobe) begin
                checkWord(nWords);
                nWords++;
            end
            if (status.done) begin
                gotDone = 1'b1;
                if (status.busy) reportProblem("busy is still high in the done cycle");
            end else begin
                @(posedge clk);
                start.strobe   <= 1'b0;
                pointIn.strobe <= 1'b0;
            end
        end
        if (nSamp != expLen) reportMismatch("sample count", nSamp, expLen);
        if (nWords != (expLen + PACK - 1) / PACK)
            reportMismatch("word count", nWords, (expLen + PACK - 1) / PACK);
        if (testErrs == 0) begin
            passCount++;
            $display("test %0d (%0d points, nop %0d): ok", t, tbl[t].numPts, tbl[t].nop);
        end else begin
            failCount++;
            $display("test %0d (%0d points, nop %0d): %0d errors", t, tbl[t].numPts,
                     tbl[t].nop, testErrs);
        end
    endtask

    task automatic fillTable();
        tbl[0]  = '{5'd6,  5'd6,  PAT_HAND,  1'b0};
        tbl[1]  = '{5'd5,  5'd3,  PAT_HAND,  1'b0};
        tbl[2]  = '{5'd3,  5'd7,  PAT_HAND,  1'b0};
        tbl[3]  = '{5'd16, 5'd16, PAT_RAND,  1'b0};
        tbl[4]  = '{5'd16, 5'd5,  PAT_RAND,  1'b1};
        tbl[5]  = '{5'd7,  5'd7,  PAT_EQUAL, 1'b0};
        tbl[6]  = '{5'd4,  5'd10, PAT_EQUAL, 1'b0};
        tbl[7]  = '{5'd4,  5'd0,  PAT_RAND,  1'b0};
        tbl[8]  = '{5'd16, 5'd1,  PAT_RAND,  1'b0};
        tbl[9]  = '{5'd0,  5'd5,  PAT_RAND,  1'b0};
        tbl[10] = '{5'd11, 5'd9,  PAT_RAND,  1'b1};
        handVal[0] = '{0, 10, 20, 100, 200, 50, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
        handSeq[0] = '{0, 4, 3, 5, 2, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
        // Points 3 and 4 tie for the third pick
        handVal[1] = '{50, 0, 250, 120, 180, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
        handSeq[1] = '{0, 2, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
        handVal[2] = '{5, 6, 200, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
        handSeq[2] = '{0, 2, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
    endtask

    //========================================
    // Main sequence
    //========================================
    initial begin
        rst_n     = 1'b0;
        pointIn   = '0;
        start     = '0;
        passCount = 0;
        failCount = 0;
        void'($urandom(21));
        fillTable();
        tableReady = 1'b1;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            runTest(t);
        end
        $display("Summary: %0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog, budget grows with points and samples of every entry
    initial begin
        longint limit;
        wait (tableReady);
        limit = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit += longint'(int'(tbl[t].numPts) + 2) * longint'(int'(tbl[t].nop) + 1) * 10;
        end
        limit += longint'(NUM_TESTS) * 300 + 500;
        #(limit);
        $display("ERROR: watchdog expired after %0d ns, the sampler never finished", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- include/fps_defines.svh
// Farthest-point sampler sizing
// Coordinate, index and packing widths shared by all blocks

`ifndef FPS_DEFINES_SVH
`define FPS_DEFINES_SVH

// Point geometry
`define FPS_CRD_WIDTH   8
`define FPS_CRD_DIM     3

// Point store and index sizing
`define FPS_MAX_POINTS  16
`define FPS_IDX_WIDTH   4
`define FPS_CNT_WIDTH   5

// Indices per packed output word
`define FPS_PACK_NUM    4

// Squared distance, two coordinate widths plus carry room for three terms
`define FPS_DIST_WIDTH  (2 * `FPS_CRD_WIDTH + 2)

`endif

//--- source/fpsCfgPkg.sv
// Farthest-point sampler command and status types
// Start command into the engine, busy and done back out

`include "fps_defines.svh"

package fpsCfgPkg;

    // Start strobe with requested number of samples
    typedef struct packed {
        logic                       strobe;
        logic [`FPS_CNT_WIDTH-1:0]  nop;
    } startCmd_t;

    // Busy level and done strobe
    // Done is a single cycle, busy drops with it
    typedef struct packed {
        logic busy;
        logic done;
    } engineStatus_t;

endpackage

//--- source/fpsDataPkg.sv
// Farthest-point sampler data types
// Points, distances, samples and packed index words

`include "fps_defines.svh"

package fpsDataPkg;

    // Bits needed to count 0..FPS_PACK_NUM filled slots
    localparam int SLOT_WIDTH = $clog2(`FPS_PACK_NUM + 1);

    // One point, coordinate 0 in the low byte
    typedef logic [`FPS_CRD_DIM-1:0][`FPS_CRD_WIDTH-1:0] coord_t;

    typedef logic [`FPS_DIST_WIDTH-1:0] dist_t;

    typedef struct packed {
        logic   strobe;
        coord_t coord;
    } pointWrite_t;

    typedef struct packed {
        logic                       strobe;
        logic [`FPS_IDX_WIDTH-1:0]  idx;
        coord_t                     coord;
        logic                       last;
    } sample_t;

    // Slot 0 holds the earliest index of the word
    typedef struct packed {
        logic                                           strobe;
        logic [`FPS_IDX_WIDTH-1:0]                      addr;
        logic [SLOT_WIDTH-1:0]                          numValid;
        logic [`FPS_PACK_NUM-1:0][`FPS_IDX_WIDTH-1:0]   idx;
    } packedWord_t;

endpackage

//--- source/fpsTop.sv
// Farthest-point sampler top level
// Point store feeds the sampling engine, whose samples are also packed
// into index words

`timescale 1ns/1ns

`include "fps_defines.svh"

module fpsTop (
    input  logic                        clk,
    input  logic                        rst_n,
    input  fpsDataPkg::pointWrite_t     pointIn,
    input  fpsCfgPkg::startCmd_t        start,
    output fpsCfgPkg::engineStatus_t    status,
    output fpsDataPkg::sample_t         sample,
    output fpsDataPkg::packedWord_t     word
);

    // Engine read port into the point store
    logic [`FPS_IDX_WIDTH-1:0]  rdIdx;
    fpsDataPkg::coord_t         rdCoord;
    logic [`FPS_CNT_WIDTH-1:0]  count;

    pointBuffer uPointBuffer (
        .clk     (clk),
        .rst_n   (rst_n),
        .pointIn (pointIn),
        .status  (status),
        .rdIdx   (rdIdx),
        .rdCoord (rdCoord),
        .count   (count)
    );

    sampleEngine uSampleEngine (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .count   (count),
        .rdIdx   (rdIdx),
        .rdCoord (rdCoord),
        .status  (status),
        .sample  (sample)
    );

    indexPacker uIndexPacker (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (sample),
        .word   (word)
    );

endmodule

//--- source/indexPacker.sv
// Sample index packer
// Collects selected indices four to a word with a running word address
// and flushes a partly filled word after the last sample of a run

`timescale 1ns/1ns

`include "fps_defines.svh"

module indexPacker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fpsDataPkg::sample_t     sample,
    output fpsDataPkg::packedWord_t word
);

    logic [fpsDataPkg::SLOT_WIDTH-1:0]              slotCnt;
    logic [`FPS_IDX_WIDTH-1:0]                      wordAddr;
    logic [`FPS_PACK_NUM-1:0][`FPS_IDX_WIDTH-1:0]   slots;
    logic [`FPS_PACK_NUM-1:0][`FPS_IDX_WIDTH-1:0]   filled;
    logic                                           wordFull;
    fpsDataPkg::packedWord_t                        wordQ;

    //========================================
    // Slot fill
    //========================================
    always_comb begin
        filled = slots;
        for (int i = 0; i < `FPS_PACK_NUM; i++) begin
            if (fpsDataPkg::SLOT_WIDTH'(i) == slotCnt) begin
                filled[i] = sample.idx;
            end
        end
    end

    assign wordFull = (slotCnt == fpsDataPkg::SLOT_WIDTH'(`FPS_PACK_NUM - 1));

    //========================================
    // Word emission
    //========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slotCnt  <= '0;
            wordAddr <= '0;
            slots    <= '0;
            wordQ    <= '0;
        end else begin
            wordQ.strobe <= 1'b0;
            if (sample.strobe) begin
                if (wordFull || sample.last) begin
                    wordQ <= '{strobe: 1'b1, addr: wordAddr,
                               numValid: slotCnt + fpsDataPkg::SLOT_WIDTH'(1),
                               idx: filled};
                    slotCnt <= '0;
                    // Unused slots of a partial word read as zero
                    slots   <= '0;
                    if (sample.last) begin
                        wordAddr <= '0;
                    end else begin
                        wordAddr <= wordAddr + `FPS_IDX_WIDTH'(1);
                    end
                end else begin
                    slots   <= filled;
                    slotCnt <= slotCnt + fpsDataPkg::SLOT_WIDTH'(1);
                end
            end
        end
    end

    assign word = wordQ;

endmodule

//--- source/pointBuffer.sv
// Point store of the farthest-point sampler
// Collects incoming points while the engine is idle, counts them and
// serves coordinates to the engine through a combinational read port

`timescale 1ns/1ns

`include "fps_defines.svh"

module pointBuffer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  fpsDataPkg::pointWrite_t     pointIn,
    input  fpsCfgPkg::engineStatus_t    status,
    input  logic [`FPS_IDX_WIDTH-1:0]   rdIdx,
    output fpsDataPkg::coord_t          rdCoord,
    output logic [`FPS_CNT_WIDTH-1:0]   count
);

    fpsDataPkg::coord_t pointMem [`FPS_MAX_POINTS];

    // Next free slot, equal to the number of loaded points
    logic [`FPS_CNT_WIDTH-1:0] wrPtr;
    logic                      isFull;
    logic                      wrAccept;

    assign isFull   = (wrPtr == `FPS_CNT_WIDTH'(`FPS_MAX_POINTS));
    assign wrAccept = pointIn.strobe && !status.busy && !isFull;

    //========================================
    // Write pointer
    //========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr <= '0;
        end else if (status.done) begin
            // Run finished, next run needs a fresh load
            wrPtr <= '0;
        end else if (wrAccept) begin
            wrPtr <= wrPtr + `FPS_CNT_WIDTH'(1);
        end
    end

    //========================================
    // Storage
    //========================================
    always_ff @(posedge clk) begin
        if (wrAccept && !status.done) begin
            pointMem[wrPtr[`FPS_IDX_WIDTH-1:0]] <= pointIn.coord;
        end
    end

    assign rdCoord = pointMem[rdIdx];
    assign count   = wrPtr;

endmodule

//--- source/sampleEngine.sv
// Farthest-point sampling engine
// Picks point 0 first, then repeatedly scans all loaded points, one per
// cycle, lowering each point's minimum squared distance to the chosen set
// and selecting the unselected point with the largest minimum

`timescale 1ns/1ns

`include "fps_defines.svh"

module sampleEngine (
    input  logic                        clk,
    input  logic                        rst_n,
    input  fpsCfgPkg::startCmd_t        start,
    input  logic [`FPS_CNT_WIDTH-1:0]   count,
    output logic [`FPS_IDX_WIDTH-1:0]   rdIdx,
    input  fpsDataPkg::coord_t          rdCoord,
    output fpsCfgPkg::engineStatus_t    status,
    output fpsDataPkg::sample_t         sample
);

    typedef enum logic [1:0] {
        StIdle,
        StFirst,
        StScan
    } state_t;

    state_t                         state;
    logic [`FPS_CNT_WIDTH-1:0]      effCnt;
    logic [`FPS_CNT_WIDTH-1:0]      effCntReq;
    logic [`FPS_CNT_WIDTH-1:0]      numSel;
    logic [`FPS_IDX_WIDTH-1:0]      scanIdx;
    logic [`FPS_MAX_POINTS-1:0]     selMask;
    fpsDataPkg::coord_t             centre;
    fpsDataPkg::dist_t              minDist [`FPS_MAX_POINTS];
    fpsDataPkg::sample_t            sampleQ;
    logic                           doneQ;

    // Running best of the current scan
    logic                           bestValid;
    fpsDataPkg::dist_t              bestDist;
    logic [`FPS_IDX_WIDTH-1:0]      bestIdx;
    fpsDataPkg::coord_t             bestCoord;

    // Candidate evaluation
    fpsDataPkg::dist_t              candDist;
    fpsDataPkg::dist_t              candMin;
    logic                           takeCand;
    logic                           startRun;
    logic                           finishing;
    logic                           scanStep;
    logic                           scanEnd;
    logic                           lastPick;

    assign effCntReq = (start.nop > count) ? count : start.nop;
    assign startRun  = (state == StIdle) && start.strobe;
    assign finishing = sampleQ.strobe && sampleQ.last;
    assign scanStep  = (state == StScan) && !finishing;
    assign scanEnd   = ({1'b0, scanIdx} == count - `FPS_CNT_WIDTH'(1));
    assign lastPick  = (numSel + `FPS_CNT_WIDTH'(1) == effCnt);

    // Scan index is 0 outside a scan, so point 0 is read for the first pick
    assign rdIdx = scanIdx;

    //========================================
    // Squared distance to current centre
    //========================================
    always_comb begin
        logic [`FPS_CRD_WIDTH-1:0]   absDiff;
        logic [2*`FPS_CRD_WIDTH-1:0] sq;
        candDist = '0;
        for (int d = 0; d < `FPS_CRD_DIM; d++) begin
            absDiff = (centre[d] > rdCoord[d]) ? centre[d] - rdCoord[d]
                                               : rdCoord[d] - centre[d];
            sq = {{`FPS_CRD_WIDTH{1'b0}}, absDiff} * {{`FPS_CRD_WIDTH{1'b0}}, absDiff};
            candDist = candDist + fpsDataPkg::dist_t'(sq);
        end
    end

    assign candMin = (candDist < minDist[scanIdx]) ? candDist : minDist[scanIdx];

    // Strictly greater replaces, so the lowest index wins a tie
    assign takeCand = !selMask[scanIdx] && (!bestValid || candMin > bestDist);

    //========================================
    // Minimum-distance array
    //========================================
    always_ff @(posedge clk) begin
        if (startRun) begin
            for (int i = 0; i < `FPS_MAX_POINTS; i++) begin
                minDist[i] <= '1;
            end
        end else if (scanStep) begin
            minDist[scanIdx] <= candMin;
        end
    end

    //========================================
    // Control FSM and selection
    //========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= StIdle;
            effCnt    <= '0;
            numSel    <= '0;
            scanIdx   <= '0;
            selMask   <= '0;
            centre    <= '0;
            sampleQ   <= '0;
            doneQ     <= 1'b0;
            bestValid <= 1'b0;
            bestDist  <= '0;
            bestIdx   <= '0;
            bestCoord <= '0;
        end else begin
            sampleQ.strobe <= 1'b0;
            doneQ          <= 1'b0;
            case (state)
                StIdle: begin
                    if (start.strobe) begin
                        effCnt <= effCntReq;
                        if (effCntReq == '0) begin
                            doneQ <= 1'b1;
                        end else begin
                            // Point 0 is always the first sample
                            sampleQ   <= '{strobe: 1'b1, idx: '0, coord: rdCoord,
                                           last: (effCntReq == `FPS_CNT_WIDTH'(1))};
                            centre    <= rdCoord;
                            selMask   <= `FPS_MAX_POINTS'(1);
                            numSel    <= `FPS_CNT_WIDTH'(1);
                            bestValid <= 1'b0;
                            state     <= StFirst;
                        end
                    end
                end
                StFirst: begin
                    if (finishing) begin
                        doneQ <= 1'b1;
                        state <= StIdle;
                    end else begin
                        state <= StScan;
                    end
                end
                StScan: begin
                    if (finishing) begin
                        doneQ <= 1'b1;
                        state <= StIdle;
                    end else if (scanEnd) begin
                        // Winner of this scan becomes the next centre
                        sampleQ <= '{strobe: 1'b1,
                                     idx: takeCand ? scanIdx : bestIdx,
                                     coord: takeCand ? rdCoord : bestCoord,
                                     last: lastPick};
                        selMask[takeCand ? scanIdx : bestIdx] <= 1'b1;
                        centre    <= takeCand ? rdCoord : bestCoord;
                        numSel    <= numSel + `FPS_CNT_WIDTH'(1);
                        scanIdx   <= '0;
                        bestValid <= 1'b0;
                    end else begin
                        if (takeCand) begin
                            bestValid <= 1'b1;
                            bestDist  <= candMin;
                            bestIdx   <= scanIdx;
                            bestCoord <= rdCoord;
                        end
                        scanIdx <= scanIdx + `FPS_IDX_WIDTH'(1);
                    end
                end
                default: state <= StIdle;
            endcase
        end
    end

    assign sample      = sampleQ;
    assign status.busy = (state != StIdle);
    assign status.done = doneQ;

endmodule

//--- sources.f
+incdir+include
source/fpsCfgPkg.sv
source/fpsDataPkg.sv
source/pointBuffer.sv
source/sampleEngine.sv
source/indexPacker.sv
source/fpsTop.sv
dv/fpsTb.sv
